// File: include/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// byte address width of the requester port.
`define DC_ADDR_W 32

// width of one data word.
`define DC_WORD_W 32

// words held by one cache line.
`define DC_LINE_WORDS 4

// number of lines in the direct-mapped array.
`define DC_LINES 16

`endif

// File: logic/dcache_pkg.sv
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    localparam int BOFF_W   = $clog2(`DC_WORD_W / 8);
    localparam int WSEL_W   = $clog2(`DC_LINE_WORDS);
    localparam int OFFSET_W = BOFF_W + WSEL_W;
    localparam int INDEX_W  = $clog2(`DC_LINES);
    localparam int TAG_W    = `DC_ADDR_W - INDEX_W - OFFSET_W;
    localparam int LINE_W   = `DC_WORD_W * `DC_LINE_WORDS;

    typedef logic [`DC_WORD_W-1:0]     dc_word_t;
    typedef logic [`DC_WORD_W/8-1:0]   dc_strb_t;
    typedef logic [LINE_W-1:0]         dc_line_t;
    typedef logic [TAG_W-1:0]          dc_tag_t;
    typedef logic [INDEX_W-1:0]        dc_index_t;
    typedef logic [TAG_W+INDEX_W-1:0]  dc_line_addr_t; // tag followed by index.

    typedef struct packed {
        dc_tag_t             tag;
        dc_index_t           index;
        logic [WSEL_W-1:0]   wsel;
        logic [BOFF_W-1:0]   boff;
    } dc_addr_fields_t;

    // the same address word, seen flat or split into its fields.
    typedef union packed {
        logic [`DC_ADDR_W-1:0] flat;
        dc_addr_fields_t       f;
    } dc_addr_t;

    typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, REFILL, FLUSH_READ, FLUSH_WB} dc_state_t;

endpackage

`default_nettype wire

// File: logic/line_array_if.sv
`default_nettype none

interface line_array_if;
    import dcache_pkg::*;

    dc_index_t index;
    logic      wr_en;
    dc_line_t  wr_line;
    dc_tag_t   wr_tag;
    logic      wr_valid;
    logic      wr_dirty;

    // read data, one cycle after index.
    dc_line_t  line_out;
    dc_tag_t   tag_out;
    logic      valid_out;
    logic      dirty_out;

    modport ctrl (
        output index, wr_en, wr_line, wr_tag, wr_valid, wr_dirty,
        input  line_out, tag_out, valid_out, dirty_out
    );

    modport store (
        input  index, wr_en, wr_line, wr_tag, wr_valid, wr_dirty,
        output line_out, tag_out, valid_out, dirty_out
    );

endinterface

`default_nettype wire

// File: logic/dcache_fsm.sv
`default_nettype none

module dcache_fsm (
    input  wire                              CLK,
    input  wire                              RST,
    input  wire                              req_valid,
    output logic                             req_ready,
    input  wire                              req_write,
    input  wire dcache_pkg::dc_addr_t        req_addr,
    output logic                             resp_valid,
    input  wire                              flush,
    output logic                             flush_busy,
    output logic                             l2_rd_valid,
    output dcache_pkg::dc_line_addr_t        l2_rd_addr,
    input  wire                              l2_fill_valid,
    input  wire dcache_pkg::dc_line_t        l2_fill_data,
    output logic                             l2_wb_valid,
    output dcache_pkg::dc_line_addr_t        l2_wb_addr,
    output dcache_pkg::dc_line_t             l2_wb_data,
    input  wire                              l2_wb_done,
    input  wire dcache_pkg::dc_line_t        merged_line,
    output logic                             flush_start,
    output logic                             flush_step,
    input  wire dcache_pkg::dc_index_t       flush_index,
    input  wire                              flush_last,
    line_array_if.ctrl                       arr
);
    import dcache_pkg::*;

    dc_state_t state;
    dc_state_t state_nxt;
    dc_addr_t  addr_q;
    logic      write_q;
    logic      init_done;  // keeps req_ready low for the first cycle out of reset.
    logic      accept;
    logic      hit;
    dc_index_t cur_index;

    assign req_ready = init_done & (state == IDLE) & ~flush;
    assign accept    = req_valid & req_ready;
    assign hit       = arr.valid_out & (arr.tag_out == addr_q.f.tag);

    assign flush_busy  = (state == FLUSH_READ) | (state == FLUSH_WB);
    assign l2_rd_valid = (state == REFILL);
    assign l2_rd_addr  = dc_line_addr_t'(addr_q.flat >> OFFSET_W);

    // a flush only writes back lines that are both valid and dirty.
    assign l2_wb_valid = (state == WRITEBACK)
                       | ((state == FLUSH_WB) & arr.valid_out & arr.dirty_out);
    assign l2_wb_addr  = {arr.tag_out, cur_index};
    assign l2_wb_data  = arr.line_out;

    always_comb begin
        case (state)
            IDLE:                 cur_index = req_addr.f.index; // read starts on the accepting edge.
            FLUSH_READ, FLUSH_WB: cur_index = flush_index;
            default:              cur_index = addr_q.f.index;
        endcase
    end

    assign arr.index = cur_index;

    always_comb begin
        state_nxt    = state;
        arr.wr_en    = 1'b0;
        arr.wr_line  = merged_line;
        arr.wr_tag   = addr_q.f.tag;
        arr.wr_valid = 1'b1;
        arr.wr_dirty = 1'b1;
        flush_start  = 1'b0;
        flush_step   = 1'b0;
        case (state)
            IDLE: begin
                if (init_done & flush) begin
                    flush_start = 1'b1;
                    state_nxt   = FLUSH_READ;
                end else if (accept) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    arr.wr_en = write_q; // store hit, merged line goes back dirty.
                    state_nxt = IDLE;
                end else if (arr.valid_out & arr.dirty_out) begin
                    state_nxt = WRITEBACK;
                end else begin
                    state_nxt = REFILL;
                end
            end
            WRITEBACK: begin
                if (l2_wb_done) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (l2_fill_valid) begin
                    arr.wr_en    = 1'b1;
                    arr.wr_line  = l2_fill_data;
                    arr.wr_dirty = 1'b0;
                    state_nxt    = LOOKUP;
                end
            end
            FLUSH_READ: state_nxt = FLUSH_WB;
            FLUSH_WB: begin
                if (~l2_wb_valid | l2_wb_done) begin
                    arr.wr_en    = 1'b1;
                    arr.wr_line  = arr.line_out;
                    arr.wr_tag   = arr.tag_out;
                    arr.wr_valid = 1'b0;
                    arr.wr_dirty = 1'b0;
                    if (flush_last) begin
                        state_nxt = IDLE;
                    end else begin
                        flush_step = 1'b1;
                        state_nxt  = FLUSH_READ;
                    end
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state      <= IDLE;
            init_done  <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            state      <= state_nxt;
            init_done  <= 1'b1;
            resp_valid <= (state == LOOKUP) & hit;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            addr_q  <= req_addr;
            write_q <= req_write;
        end
    end

endmodule

`default_nettype wire

// File: logic/flush_counter.sv
`default_nettype none

`include "dcache_settings.svh"

module flush_counter (
    input  wire                         CLK,
    input  wire                         RST,
    input  wire                         start,
    input  wire                         step,
    output dcache_pkg::dc_index_t       index,
    output logic                        last
);
    import dcache_pkg::*;

    // start wins over step so a new flush always begins at line zero.
    always_ff @(posedge CLK) begin
        if (RST) begin
            index <= '0;
        end else if (start) begin
            index <= '0;
        end else if (step) begin
            index <= index + 1'b1;
        end
    end

    assign last = (index == dc_index_t'(`DC_LINES - 1));

endmodule

`default_nettype wire

// File: logic/line_store.sv
`default_nettype none

`include "dcache_settings.svh"

module line_store (
    input  wire          CLK,
    input  wire          RST,
    line_array_if.store  arr
);
    import dcache_pkg::*;

    dc_line_t              data_mem [`DC_LINES];
    dc_tag_t               tag_mem  [`DC_LINES];
    logic [`DC_LINES-1:0]  valid_q;
    logic [`DC_LINES-1:0]  dirty_q;

    always_ff @(posedge CLK) begin
        if (arr.wr_en) begin
            data_mem[arr.index] <= arr.wr_line;
            tag_mem[arr.index]  <= arr.wr_tag;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (arr.wr_en) begin
            valid_q[arr.index] <= arr.wr_valid;
            dirty_q[arr.index] <= arr.wr_dirty;
        end
    end

    // the read port returns the new contents when the same line is written,
    // so the lookup after a refill sees the filled line.
    always_ff @(posedge CLK) begin
        if (arr.wr_en) begin
            arr.line_out  <= arr.wr_line;
            arr.tag_out   <= arr.wr_tag;
            arr.valid_out <= arr.wr_valid;
            arr.dirty_out <= arr.wr_dirty;
        end else begin
            arr.line_out  <= data_mem[arr.index];
            arr.tag_out   <= tag_mem[arr.index];
            arr.valid_out <= valid_q[arr.index];
            arr.dirty_out <= dirty_q[arr.index];
        end
    end

endmodule

`default_nettype wire

// File: logic/word_lane.sv
`default_nettype none

`include "dcache_settings.svh"

module word_lane (
    input  wire                         CLK,
    input  wire                         RST,
    input  wire                         accept,
    input  wire dcache_pkg::dc_addr_t   req_addr,
    input  wire dcache_pkg::dc_word_t   req_wdata,
    input  wire dcache_pkg::dc_strb_t   req_wstrb,
    input  wire dcache_pkg::dc_line_t   line_in,
    output dcache_pkg::dc_word_t        rd_word,
    output dcache_pkg::dc_line_t        merged_line
);
    import dcache_pkg::*;

    logic [WSEL_W-1:0] wsel_q;
    dc_word_t          wdata_q;
    dc_strb_t          wstrb_q;
    dc_word_t          merged_word;

    always_ff @(posedge CLK) begin
        if (RST) begin
            wstrb_q <= '0;
        end else if (accept) begin
            wstrb_q <= req_wstrb;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            wsel_q  <= req_addr.f.wsel;
            wdata_q <= req_wdata;
        end
    end

    assign rd_word = line_in[wsel_q*`DC_WORD_W +: `DC_WORD_W];

    always_comb begin
        for (int b = 0; b < `DC_WORD_W / 8; b++) begin
            merged_word[b*8 +: 8] = wstrb_q[b] ? wdata_q[b*8 +: 8] : rd_word[b*8 +: 8];
        end
    end

    // other words of the line pass through unchanged.
    always_comb begin
        merged_line = line_in;
        merged_line[wsel_q*`DC_WORD_W +: `DC_WORD_W] = merged_word;
    end

endmodule

`default_nettype wire

// File: logic/dcache_top.sv
`default_nettype none

module dcache_top (
    input  wire                              CLK,
    input  wire                              RST,
    input  wire                              req_valid,
    output wire                              req_ready,
    input  wire                              req_write,
    input  wire dcache_pkg::dc_addr_t        req_addr,
    input  wire dcache_pkg::dc_word_t        req_wdata,
    input  wire dcache_pkg::dc_strb_t        req_wstrb,
    output wire                              resp_valid,
    output wire dcache_pkg::dc_word_t        resp_rdata,
    input  wire                              flush,
    output wire                              flush_busy,
    output wire                              l2_rd_valid,
    output wire dcache_pkg::dc_line_addr_t   l2_rd_addr,
    input  wire                              l2_fill_valid,
    input  wire dcache_pkg::dc_line_t        l2_fill_data,
    output wire                              l2_wb_valid,
    output wire dcache_pkg::dc_line_addr_t   l2_wb_addr,
    output wire dcache_pkg::dc_line_t        l2_wb_data,
    input  wire                              l2_wb_done
);
    import dcache_pkg::*;

    dc_line_t  merged_line;
    dc_index_t flush_index;
    logic      flush_start;
    logic      flush_step;
    logic      flush_last;
    logic      accept;

    assign accept = req_valid & req_ready; // same edge on which the controller takes the request.

    line_array_if arr_if ();

    dcache_fsm fsm_inst (
        .CLK           (CLK),
        .RST           (RST),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .resp_valid    (resp_valid),
        .flush         (flush),
        .flush_busy    (flush_busy),
        .l2_rd_valid   (l2_rd_valid),
        .l2_rd_addr    (l2_rd_addr),
        .l2_fill_valid (l2_fill_valid),
        .l2_fill_data  (l2_fill_data),
        .l2_wb_valid   (l2_wb_valid),
        .l2_wb_addr    (l2_wb_addr),
        .l2_wb_data    (l2_wb_data),
        .l2_wb_done    (l2_wb_done),
        .merged_line   (merged_line),
        .flush_start   (flush_start),
        .flush_step    (flush_step),
        .flush_index   (flush_index),
        .flush_last    (flush_last),
        .arr           (arr_if.ctrl)
    );

    flush_counter flush_counter_inst (
        .CLK   (CLK),
        .RST   (RST),
        .start (flush_start),
        .step  (flush_step),
        .index (flush_index),
        .last  (flush_last)
    );

    line_store line_store_inst (
        .CLK (CLK),
        .RST (RST),
        .arr (arr_if.store)
    );

    word_lane word_lane_inst (
        .CLK         (CLK),
        .RST         (RST),
        .accept      (accept),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .line_in     (arr_if.line_out),
        .rd_word     (resp_rdata),
        .merged_line (merged_line)
    );

endmodule

`default_nettype wire

// File: tb/l2_memory_model.sv
`default_nettype none

`include "dcache_settings.svh"

module l2_memory_model (
    input  wire                              CLK,
    input  wire                              RST,
    input  var int                           rd_delay,
    input  var int                           wb_delay,
    input  wire                              l2_rd_valid,
    input  wire dcache_pkg::dc_line_addr_t   l2_rd_addr,
    output logic                             l2_fill_valid,
    output dcache_pkg::dc_line_t             l2_fill_data,
    input  wire                              l2_wb_valid,
    input  wire dcache_pkg::dc_line_addr_t   l2_wb_addr,
    input  wire dcache_pkg::dc_line_t        l2_wb_data,
    output logic                             l2_wb_done,
    input  wire dcache_pkg::dc_line_addr_t   peek_addr,
    output dcache_pkg::dc_line_t             peek_line
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    dc_line_t    mem [dc_line_addr_t]; // lines never written back still hold the initial pattern.
    int          rd_wait;
    int          wb_wait;
    int unsigned wr_count;

    function automatic dc_line_t read_line(dc_line_addr_t la);
        dc_line_t line;
        if (mem.exists(la)) begin
            return mem[la];
        end
        for (int w = 0; w < `DC_LINE_WORDS; w++) begin
            line[w*`DC_WORD_W +: `DC_WORD_W] = (32'({la, 2'(w)}) * 32'h9e3779b1) ^ 32'h5a5a0f0f;
        end
        return line;
    endfunction

    always @(peek_addr or wr_count) begin
        peek_line = read_line(peek_addr);
    end

    initial begin
        l2_fill_valid = 1'b0;
        l2_fill_data  = '0;
        l2_wb_done    = 1'b0;
        rd_wait       = 0;
        wb_wait       = 0;
        wr_count      = 0;
    end

    // answers are pulses that change 10 ns after the rising edge.
    always begin
        @(posedge CLK);
        #10;
        l2_fill_valid = 1'b0;
        l2_wb_done    = 1'b0;
        if (RST || !l2_rd_valid) begin
            rd_wait = 0;
        end else if (rd_wait >= rd_delay) begin
            l2_fill_data  = read_line(l2_rd_addr);
            l2_fill_valid = 1'b1;
            rd_wait       = 0;
        end else begin
            rd_wait++;
        end
        if (RST || !l2_wb_valid) begin
            wb_wait = 0;
        end else if (wb_wait >= wb_delay) begin
            mem[l2_wb_addr] = l2_wb_data;
            wr_count++;
            l2_wb_done = 1'b1;
            wb_wait    = 0;
        end else begin
            wb_wait++;
        end
    end

endmodule

`default_nettype wire

// File: tb/dcache_assertions.sv
`default_nettype none

module dcache_assertions (
    input  wire                              CLK,
    input  wire                              RST,
    input  wire                              req_ready,
    input  wire                              resp_valid,
    input  wire                              flush_busy,
    input  wire                              l2_rd_valid,
    input  wire dcache_pkg::dc_line_addr_t   l2_rd_addr,
    input  wire                              l2_fill_valid,
    input  wire                              l2_wb_valid,
    input  wire dcache_pkg::dc_line_addr_t   l2_wb_addr,
    input  wire dcache_pkg::dc_line_t        l2_wb_data,
    input  wire                              l2_wb_done,
    input  wire dcache_pkg::dc_state_t       state
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    rd_held: assert property (@(posedge CLK) disable iff (RST)
        l2_rd_valid && !l2_fill_valid |=> l2_rd_valid && $stable(l2_rd_addr))
        else $error("refill request dropped or changed before the fill arrived.");

    wb_held: assert property (@(posedge CLK) disable iff (RST)
        l2_wb_valid && !l2_wb_done |=> l2_wb_valid && $stable(l2_wb_addr) && $stable(l2_wb_data))
        else $error("writeback request dropped or changed before it was done.");

    // no new request is taken while L2 is busy for the cache.
    miss_blocks: assert property (@(posedge CLK) disable iff (RST)
        (l2_rd_valid || l2_wb_valid) |-> !req_ready)
        else $error("req_ready high during a miss.");

    resp_pulse: assert property (@(posedge CLK) disable iff (RST) resp_valid |=> !resp_valid)
        else $error("resp_valid longer than one cycle.");

    resp_no_flush: assert property (@(posedge CLK) disable iff (RST) resp_valid |-> !flush_busy)
        else $error("resp_valid during a flush.");

    // L2 answers a refill only while the controller waits for it.
    fill_in_refill: assert property (@(posedge CLK) disable iff (RST)
        l2_fill_valid |-> state == REFILL)
        else $error("refill data arrived outside REFILL.");

endmodule

bind dcache_top dcache_assertions assertions_inst (
    .CLK           (CLK),
    .RST           (RST),
    .req_ready     (req_ready),
    .resp_valid    (resp_valid),
    .flush_busy    (flush_busy),
    .l2_rd_valid   (l2_rd_valid),
    .l2_rd_addr    (l2_rd_addr),
    .l2_fill_valid (l2_fill_valid),
    .l2_wb_valid   (l2_wb_valid),
    .l2_wb_addr    (l2_wb_addr),
    .l2_wb_data    (l2_wb_data),
    .l2_wb_done    (l2_wb_done),
    .state         (fsm_inst.state)
);

`default_nettype wire

// File: tb/dcache_tb.sv
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int MAX_DELAY      = 15;
    localparam int N_OPS          = 8 * 2 + 24 * 2 + 6 * 2 + 40 + 1;
    localparam int MISS_CYCLES    = 2 * (MAX_DELAY + 2) + 8;
    localparam int TIMEOUT_CYCLES = (N_OPS + `DC_LINES) * MISS_CYCLES + 100;
    localparam logic [19:0] TAG_BASE = 20'h3c5a1; // low four tag bits vary, so 256 lines are used.

    logic          CLK, RST, req_valid, req_ready, req_write, resp_valid, flush, flush_busy;
    logic          l2_rd_valid, l2_fill_valid, l2_wb_valid, l2_wb_done;
    dc_addr_t      req_addr;
    dc_word_t      req_wdata, resp_rdata, pending_exp;
    dc_strb_t      req_wstrb;
    dc_line_addr_t l2_rd_addr, l2_wb_addr, peek_addr, last_wb_addr;
    dc_line_t      l2_fill_data, l2_wb_data, peek_line;
    int            rd_delay, wb_delay;
    int            refill_count = 0;
    int            wb_count = 0;
    logic          pending_read = 1'b0;
    logic          rd_hold = 1'b0;
    logic          wb_hold = 1'b0;
    logic [31:0]   lfsr = 32'h356fb028;
    dc_word_t      shadow [logic [29:0]]; // every word the testbench has written.

    dcache_top dcache_top_inst (.*);
    l2_memory_model l2_inst (.*);

    always #50 CLK = ~CLK;

    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic dc_addr_t random_addr();
        dc_addr_t a;
        a.flat    = '0;
        a.f.tag   = {TAG_BASE, 4'(random_bits(4))};
        a.f.index = dc_index_t'(random_bits(4));
        a.f.wsel  = 2'(random_bits(2));
        return a;
    endfunction

    // a word holds its last written bytes or else what L2 held from the start.
    function automatic dc_word_t expected_word(dc_addr_t a);
        if (shadow.exists(a.flat[31:2])) begin
            return shadow[a.flat[31:2]];
        end
        return (32'(a.flat[31:2]) * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    function automatic dc_line_t shadow_line(dc_line_addr_t la);
        dc_line_t line;
        for (int w = 0; w < `DC_LINE_WORDS; w++) begin
            line[w*`DC_WORD_W +: `DC_WORD_W] = expected_word(dc_addr_t'({la, 2'(w), 2'b00}));
        end
        return line;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input dc_word_t actual, input dc_word_t expected, input string what);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                                    $time, what, actual, expected));
        end
    endtask

    task automatic check_line(input dc_line_t actual, input dc_line_t expected, input string what);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                                    $time, what, actual, expected));
        end
    endtask

    task automatic check_addr(input dc_line_addr_t actual, input dc_line_addr_t expected,
                              input string what);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                                    $time, what, actual, expected));
        end
    endtask

    // drives one request through the handshake and counts cycles from acceptance to resp_valid.
    task automatic access(input logic write, input dc_addr_t addr, input dc_word_t wdata,
                          input dc_strb_t wstrb, input logic long_delay, output int latency);
        dc_word_t merged;
        @(posedge CLK);
        #10;
        rd_delay     = long_delay ? 8 + int'(random_bits(3)) : int'(random_bits(2));
        wb_delay     = long_delay ? 8 + int'(random_bits(3)) : int'(random_bits(2));
        merged       = expected_word(addr);
        pending_read = !write;
        pending_exp  = merged;
        if (write) begin
            for (int b = 0; b < `DC_WORD_W / 8; b++) begin
                if (wstrb[b]) merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
            shadow[addr.flat[31:2]] = merged;
        end
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = wstrb;
        do @(negedge CLK); while (!req_ready);
        @(posedge CLK);
        #10;
        req_valid = 1'b0;
        latency   = 0;
        do begin
            @(negedge CLK);
            latency++;
        end while (!resp_valid);
    endtask

    task automatic run_flush();
        @(posedge CLK);
        #10;
        flush = 1'b1;
        @(posedge CLK);
        #10;
        flush = 1'b0;
        if (!flush_busy) stop_on_error("the flush request was not taken in IDLE");
        do @(negedge CLK); while (flush_busy);
    endtask

    always @(negedge CLK) begin
        if (!RST) begin
            if (rd_hold && !l2_rd_valid) stop_on_error("l2_rd_valid dropped before its fill");
            if (wb_hold && !l2_wb_valid) stop_on_error("l2_wb_valid dropped before it was done");
            if ((l2_rd_valid || l2_wb_valid) && req_ready) begin
                stop_on_error("req_ready was high while a miss was waiting on L2");
            end
            if (l2_rd_valid && !rd_hold) refill_count++;
            if (l2_wb_valid && l2_wb_done) begin
                check_line(l2_wb_data, shadow_line(l2_wb_addr), "writeback data");
                last_wb_addr = l2_wb_addr;
                wb_count++;
            end
            if (resp_valid && pending_read) check_word(resp_rdata, pending_exp, "read data");
            rd_hold = l2_rd_valid && !l2_fill_valid;
            wb_hold = l2_wb_valid && !l2_wb_done;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * 100);
        $display("timeout: the cache did not finish the test sequence in time");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        dc_addr_t a;
        dc_addr_t b;
        int       lat;
        int       n;
        CLK       = 1'b0;
        RST       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        flush     = 1'b0;
        rd_delay  = 0;
        wb_delay  = 0;
        peek_addr = '0;
        repeat (8) @(posedge CLK);
        #10;
        RST = 1'b0;
        repeat (8) begin // a miss and then a hit on the same line.
            a = random_addr();
            access(1'b0, a, '0, '0, 1'b0, lat);
            a.f.wsel = 2'(random_bits(2));
            access(1'b0, a, '0, '0, 1'b0, lat);
            if (lat != 2) begin
                stop_on_error($sformatf("FAILED at %0t ns: hit took %0d cycles, expected 2",
                                        $time, lat));
            end
        end
        repeat (24) begin
            a = random_addr();
            access(1'b1, a, random_bits(32), dc_strb_t'(random_bits(4)), 1'b0, lat);
            access(1'b0, a, '0, '0, 1'b0, lat);
        end
        // same index with another tag evicts the dirty line.
        repeat (6) begin
            a = random_addr();
            access(1'b1, a, random_bits(32), 4'hf, 1'b0, lat);
            b = a;
            b.f.tag[3:0] = a.f.tag[3:0] ^ 4'(random_bits(3) + 1);
            n = wb_count;
            access(1'b0, b, '0, '0, 1'b0, lat);
            if (wb_count == n) stop_on_error("no writeback was seen for the dirty victim line");
            check_addr(last_wb_addr, {a.f.tag, a.f.index}, "writeback address");
        end
        repeat (40) begin
            a = random_addr();
            access(random_bits(1) == 1, a, random_bits(32), dc_strb_t'(random_bits(4)),
                   1'b1, lat);
        end
        run_flush();
        for (int i = 0; i < 256; i++) begin
            peek_addr = {TAG_BASE, 8'(i)};
            #1;
            check_line(peek_line, shadow_line(peek_addr), "L2 line after flush");
        end
        n = refill_count;
        access(1'b0, a, '0, '0, 1'b0, lat);
        if (refill_count == n) stop_on_error("a read after the flush was not served by a refill");
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
logic/dcache_pkg.sv
logic/line_array_if.sv
logic/dcache_fsm.sv
logic/flush_counter.sv
logic/line_store.sv
logic/word_lane.sv
logic/dcache_top.sv
tb/l2_memory_model.sv
tb/dcache_assertions.sv
tb/dcache_tb.sv
